// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_processing_swappable
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing -j 0
EXTRA     ?=
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
rtl/nabp_pkg.sv
rtl/shift_ctrl_if.sv
rtl/state_control.sv
rtl/shifter.sv
rtl/mapper.sv
rtl/line_buffer.sv
rtl/processing_swappable.sv
dv/tb_processing_swappable.sv

// ==== dv/tb_processing_swappable.sv ====
module tb_processing_swappable;
    timeunit 1ns;
    timeprecision 100ps;
    import nabp_pkg::*;

    localparam int LINE_SIZE      = 16;
    localparam int NO_PARTITIONS  = 4;
    localparam int PARTITION_SIZE = 4;

    // request wait, kicks, dones and swap ack of one iteration
    localparam int ITER_OVERHEAD = 10;
    localparam int RESET_CYCLES  = 5;
    localparam int WORST_CYCLES  = RESET_CYCLES + 6
        + (ITER_OVERHEAD + 8 + LINE_SIZE)
        + (ITER_OVERHEAD + 5 + LINE_SIZE)
        + (ITER_OVERHEAD + 4 + LINE_SIZE + 10)
        + (ITER_OVERHEAD + 0 + LINE_SIZE + 1);
    localparam int MAX_CYCLES = WORST_CYCLES * 12 / 10;

    logic      clk;
    logic      rst_n;
    fill_len_t sw_sh_accu_base;
    accu_t     sw_mp_accu_init;
    accu_t     sw_mp_accu_base;
    logic      sw_swap_ack;
    logic      sw_next_itr_ack;
    data_t     fr_val;
    logic      sw_swap;
    logic      sw_next_itr;
    logic      sw_pe_en;
    s_val_t    fr_s_val;
    data_t [NO_PARTITIONS-1:0] pe_taps;

    data_t  ram [0:255];
    s_val_t ram_addr;
    int     seed;
    int     cycle_count;
    int     s_errors;
    int     tap_errors;
    int     bit_errors;

    processing_swappable i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .sw_sh_accu_base (sw_sh_accu_base),
        .sw_mp_accu_init (sw_mp_accu_init),
        .sw_mp_accu_base (sw_mp_accu_base),
        .sw_swap_ack     (sw_swap_ack),
        .sw_next_itr_ack (sw_next_itr_ack),
        .fr_val          (fr_val),
        .sw_swap         (sw_swap),
        .sw_next_itr     (sw_next_itr),
        .sw_pe_en        (sw_pe_en),
        .fr_s_val        (fr_s_val),
        .pe_taps         (pe_taps)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // filtered RAM model with one cycle read latency
    initial begin
        forever begin
            @(posedge clk);
            #2;
            fr_val   = ram[ram_addr];
            ram_addr = fr_s_val;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_s(input s_val_t got, input s_val_t exp, input string what);
        if (got !== exp) begin
            s_errors++;
            $display("FAILED at %0t: %s, fr_s_val %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_tap(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            tap_errors++;
            $display("FAILED at %0t: %s, tap %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            bit_errors++;
            $display("FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // integer part of init + k * step modulo 2^16
    function automatic s_val_t expected_s(input accu_t init, input accu_t step, input int k);
        logic [31:0] full;
        full = 32'(init) + 32'(k) * 32'(step);
        return full[15:8];
    endfunction

    // tap i holds the sample of step n_loads-1-i*PARTITION_SIZE
    function automatic data_t expected_tap(input accu_t init, input accu_t step,
                                           input int n_loads, input int i);
        int k;
        k = n_loads - 1 - i * PARTITION_SIZE;
        if (k < 0) begin
            return '0;
        end
        return ram[expected_s(init, step, k)];
    endfunction

    task automatic compare_taps(input accu_t init, input accu_t step,
                                input int n_loads, input string what);
        for (int i = 0; i < NO_PARTITIONS; i++) begin
            check_tap(pe_taps[i], expected_tap(init, step, n_loads, i),
                      $sformatf("%s, tap %0d", what, i));
        end
    endtask

    task automatic run_iteration(input fill_len_t fill, input accu_t init, input accu_t step,
                                 input int swap_delay);
        int pe_cycles;
        int n_loads;
        pe_cycles = 0;
        n_loads   = int'(fill) + LINE_SIZE;
        while (!sw_next_itr) begin
            next_cycle();
        end
        sw_sh_accu_base = fill;
        sw_mp_accu_init = init;
        sw_mp_accu_base = step;
        sw_next_itr_ack = 1'b1;
        next_cycle();
        sw_next_itr_ack = 1'b0;
        // parameters are valid only in the ack cycle
        sw_sh_accu_base = ~fill;
        sw_mp_accu_init = ~init;
        sw_mp_accu_base = ~step;
        check_bit(sw_next_itr, 1'b0, "sw_next_itr after its ack");
        // ack clears the line buffer
        compare_taps(init, step, 0, "taps after next-iteration ack");
        while (!sw_swap) begin
            if (sw_pe_en) begin
                check_s(fr_s_val, expected_s(init, step, int'(fill) + pe_cycles),
                        $sformatf("shift cycle %0d", pe_cycles));
                pe_cycles++;
            end
            next_cycle();
        end
        check_bit(pe_cycles == LINE_SIZE, 1'b1, "sw_pe_en length equals LINE_SIZE");
        compare_taps(init, step, n_loads, "taps at swap");
        check_bit(sw_next_itr, 1'b0, "sw_next_itr during swap request");
        for (int d = 0; d < swap_delay; d++) begin
            next_cycle();
            check_bit(sw_swap, 1'b1, "sw_swap held without ack");
            check_bit(sw_next_itr, 1'b0, "sw_next_itr during swap wait");
            compare_taps(init, step, n_loads, "taps during swap wait");
        end
        sw_swap_ack = 1'b1;
        next_cycle();
        sw_swap_ack = 1'b0;
        check_bit(sw_swap, 1'b0, "sw_swap after its ack");
        check_bit(sw_next_itr, 1'b1, "sw_next_itr one cycle after swap ack");
    endtask

    task automatic test_reset();
        bit seen;
        seen = 1'b0;
        check_bit(sw_swap, 1'b0, "sw_swap after reset");
        check_bit(sw_pe_en, 1'b0, "sw_pe_en after reset");
        check_bit(sw_next_itr, 1'b0, "sw_next_itr after reset");
        compare_taps('0, '0, 0, "taps after reset");
        for (int c = 0; c < 4 && !seen; c++) begin
            next_cycle();
            seen = sw_next_itr;
        end
        if (!seen) begin
            bit_errors++;
            $display("sw_next_itr never rose after reset");
        end
    endtask

    task automatic test_integer_step();
        run_iteration(8'd8, 16'h0300, 16'h0100, 0);
    endtask

    task automatic test_fractional_step();
        accu_t init;
        accu_t step;
        init = accu_t'($random(seed));
        step = accu_t'($random(seed));
        run_iteration(8'd5, init, step, 0);
    endtask

    task automatic test_swap_backpressure();
        int delay;
        delay = 3 + int'($unsigned($random(seed)) % 32'd8);
        run_iteration(8'd4, 16'h2040, 16'h00c0, delay);
    endtask

    // F = 0 straight after full iterations starts from cleared taps
    task automatic test_iteration_clear();
        run_iteration(8'd0, 16'h1080, 16'h0180, 1);
    endtask

    initial begin
        rst_n           = 1'b0;
        sw_sh_accu_base = '0;
        sw_mp_accu_init = '0;
        sw_mp_accu_base = '0;
        sw_swap_ack     = 1'b0;
        sw_next_itr_ack = 1'b0;
        fr_val          = '0;
        ram_addr        = '0;
        s_errors        = 0;
        tap_errors      = 0;
        bit_errors      = 0;
        seed            = 32'h74ba_99ec;
        for (int a = 0; a < 256; a++) begin
            ram[a] = data_t'($random(seed));
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_reset();
        test_integer_step();
        test_fractional_step();
        test_swap_backpressure();
        test_iteration_clear();

        next_cycle();
        $display("errors: s_val %0d, taps %0d, control %0d", s_errors, tap_errors, bit_errors);
        if (s_errors + tap_errors + bit_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== rtl/line_buffer.sv ====
module line_buffer #(
    parameter int NO_PARTITIONS  = 4,
    parameter int PARTITION_SIZE = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 clear,
    input  logic                                 enable,
    input  nabp_pkg::data_t                      shift_in,
    output nabp_pkg::data_t [NO_PARTITIONS-1:0]  taps
);
    import nabp_pkg::*;

    localparam int CHAIN_LEN = (NO_PARTITIONS - 1) * PARTITION_SIZE;

    // enable lined up with the RAM read latency
    logic en_d;

    data_t                 tap0;
    data_t [CHAIN_LEN-1:0] chain;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_d <= 1'b0;
        end else begin
            en_d <= enable;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tap0  <= '0;
            chain <= '0;
        end else if (clear) begin
            tap0  <= '0;
            chain <= '0;
        end else if (en_d) begin
            tap0     <= shift_in;
            chain[0] <= tap0;
            for (int j = 1; j < CHAIN_LEN; j++) begin
                chain[j] <= chain[j-1];
            end
        end
    end

    // every PARTITION_SIZE-th stage is a tap
    always_comb begin
        taps[0] = tap0;
        for (int i = 1; i < NO_PARTITIONS; i++) begin
            taps[i] = chain[i*PARTITION_SIZE-1];
        end
    end

endmodule

// ==== rtl/mapper.sv ====
module mapper (
    input  logic            clk,
    input  logic            rst_n,
    input  nabp_pkg::accu_t mp_accu_init,
    input  nabp_pkg::accu_t mp_accu_base,
    input  logic            sh_kick,
    input  logic            sh_shift_en,
    output nabp_pkg::s_val_t fr_s_val
);
    import nabp_pkg::*;

    accu_t accu;

    // accumulator wraps modulo 2^16
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accu <= '0;
        end else if (sh_kick) begin
            accu <= mp_accu_init;
        end else if (sh_shift_en) begin
            accu <= accu + mp_accu_base;
        end
    end

    // truncate the fraction
    assign fr_s_val = s_val_t'(accu >> ACCU_FRAC);

endmodule

// ==== rtl/nabp_pkg.sv ====
package nabp_pkg;

    // filtered sample width
    localparam int DATA_W = 12;

    // projection line address width
    localparam int S_W = 8;

    // map accumulator, 8 integer bits over ACCU_FRAC fraction bits
    localparam int ACCU_W = 16;
    localparam int ACCU_FRAC = 8;

    // fill phase length width
    localparam int FILL_W = 8;

    typedef logic signed [DATA_W-1:0] data_t;

    typedef logic [S_W-1:0] s_val_t;

    typedef logic [ACCU_W-1:0] accu_t;

    typedef logic [FILL_W-1:0] fill_len_t;

endpackage

// ==== rtl/processing_swappable.sv ====
module processing_swappable #(
    parameter int LINE_SIZE      = 16,
    parameter int NO_PARTITIONS  = 4,
    parameter int PARTITION_SIZE = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    // from the swap controller
    input  nabp_pkg::fill_len_t                 sw_sh_accu_base,
    input  nabp_pkg::accu_t                     sw_mp_accu_init,
    input  nabp_pkg::accu_t                     sw_mp_accu_base,
    input  logic                                sw_swap_ack,
    input  logic                                sw_next_itr_ack,
    // filtered RAM read data
    input  nabp_pkg::data_t                     fr_val,
    // to the swap controller
    output logic                                sw_swap,
    output logic                                sw_next_itr,
    output logic                                sw_pe_en,
    // filtered RAM address
    output nabp_pkg::s_val_t                    fr_s_val,
    // one tap per processing element
    output nabp_pkg::data_t [NO_PARTITIONS-1:0] pe_taps
);
    import nabp_pkg::*;

    shift_ctrl_if sc_sh ();

    accu_t sc_mp_accu_init;
    accu_t sc_mp_accu_base;
    logic  sh_mp_kick;
    logic  sh_shift_en;

    state_control u_state_control (
        .clk             (clk),
        .rst_n           (rst_n),
        .sw_sh_accu_base (sw_sh_accu_base),
        .sw_mp_accu_init (sw_mp_accu_init),
        .sw_mp_accu_base (sw_mp_accu_base),
        .sw_swap_ack     (sw_swap_ack),
        .sw_next_itr_ack (sw_next_itr_ack),
        .sw_swap         (sw_swap),
        .sw_next_itr     (sw_next_itr),
        .sw_pe_en        (sw_pe_en),
        .sh              (sc_sh.ctrl),
        .mp_accu_init    (sc_mp_accu_init),
        .mp_accu_base    (sc_mp_accu_base)
    );

    shifter #(
        .LINE_SIZE (LINE_SIZE)
    ) u_shifter (
        .clk      (clk),
        .rst_n    (rst_n),
        .sc       (sc_sh.shift),
        .mp_kick  (sh_mp_kick),
        .shift_en (sh_shift_en)
    );

    mapper u_mapper (
        .clk          (clk),
        .rst_n        (rst_n),
        .mp_accu_init (sc_mp_accu_init),
        .mp_accu_base (sc_mp_accu_base),
        .sh_kick      (sh_mp_kick),
        .sh_shift_en  (sh_shift_en),
        .fr_s_val     (fr_s_val)
    );

    // cleared by the next-iteration ack
    line_buffer #(
        .NO_PARTITIONS  (NO_PARTITIONS),
        .PARTITION_SIZE (PARTITION_SIZE)
    ) u_line_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (sw_next_itr_ack),
        .enable   (sh_shift_en),
        .shift_in (fr_val),
        .taps     (pe_taps)
    );

endmodule

// ==== rtl/shift_ctrl_if.sv ====
interface shift_ctrl_if;
    import nabp_pkg::*;

    // kicks from state control, one cycle each
    logic fill_kick;
    logic shift_kick;

    // fill length, held for the iteration
    fill_len_t accu_base;

    // phase completion pulses back from the shifter
    logic fill_done;
    logic shift_done;

    modport ctrl (
        output fill_kick, shift_kick, accu_base,
        input fill_done, shift_done
    );

    modport shift (
        input fill_kick, shift_kick, accu_base,
        output fill_done, shift_done
    );

endinterface

// ==== rtl/shifter.sv ====
module shifter #(
    parameter int LINE_SIZE = 16
) (
    input  logic        clk,
    input  logic        rst_n,
    shift_ctrl_if.shift sc,
    output logic        mp_kick,
    output logic        shift_en
);
    import nabp_pkg::*;

    // remaining cycles of the running phase
    fill_len_t count;
    logic      in_shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count         <= '0;
            in_shift      <= 1'b0;
            mp_kick       <= 1'b0;
            shift_en      <= 1'b0;
            sc.fill_done  <= 1'b0;
            sc.shift_done <= 1'b0;
        end else begin
            mp_kick       <= sc.fill_kick;
            sc.fill_done  <= 1'b0;
            sc.shift_done <= 1'b0;

            if (sc.fill_kick) begin
                // mapper loads next cycle, counting starts after that
                count    <= sc.accu_base;
                in_shift <= 1'b0;
            end else if (sc.shift_kick) begin
                count    <= fill_len_t'(LINE_SIZE);
                in_shift <= 1'b1;
                shift_en <= 1'b1;
            end else if (mp_kick) begin
                // empty fill phase is skipped
                if (count == '0) begin
                    sc.fill_done <= 1'b1;
                end else begin
                    shift_en <= 1'b1;
                end
            end else if (shift_en) begin
                count <= count - 1'b1;
                if (count == fill_len_t'(1)) begin
                    shift_en <= 1'b0;
                    if (in_shift) begin
                        sc.shift_done <= 1'b1;
                    end else begin
                        sc.fill_done <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== rtl/state_control.sv ====
module state_control (
    input  logic               clk,
    input  logic               rst_n,
    input  nabp_pkg::fill_len_t sw_sh_accu_base,
    input  nabp_pkg::accu_t    sw_mp_accu_init,
    input  nabp_pkg::accu_t    sw_mp_accu_base,
    input  logic               sw_swap_ack,
    input  logic               sw_next_itr_ack,
    output logic               sw_swap,
    output logic               sw_next_itr,
    output logic               sw_pe_en,
    shift_ctrl_if.ctrl         sh,
    output nabp_pkg::accu_t    mp_accu_init,
    output nabp_pkg::accu_t    mp_accu_base
);
    import nabp_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ_ITR,
        S_KICK_FILL,
        S_WAIT_FILL,
        S_KICK_SHIFT,
        S_SHIFT,
        S_REQ_SWAP
    } state_e;

    state_e state;
    state_e state_nxt;

    fill_len_t accu_base_q;
    accu_t     accu_init_q;
    accu_t     accu_step_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:       state_nxt = S_REQ_ITR;
            S_REQ_ITR:    if (sw_next_itr_ack) state_nxt = S_KICK_FILL;
            S_KICK_FILL:  state_nxt = S_WAIT_FILL;
            S_WAIT_FILL:  if (sh.fill_done) state_nxt = S_KICK_SHIFT;
            S_KICK_SHIFT: state_nxt = S_SHIFT;
            S_SHIFT:      if (sh.shift_done) state_nxt = S_REQ_SWAP;
            S_REQ_SWAP:   if (sw_swap_ack) state_nxt = S_REQ_ITR;
            default:      state_nxt = S_IDLE;
        endcase
    end

    // iteration parameters, captured in the ack cycle
    always_ff @(posedge clk) begin
        if (state == S_REQ_ITR && sw_next_itr_ack) begin
            accu_base_q <= sw_sh_accu_base;
            accu_init_q <= sw_mp_accu_init;
            accu_step_q <= sw_mp_accu_base;
        end
    end

    assign sw_next_itr = (state == S_REQ_ITR);
    assign sw_swap     = (state == S_REQ_SWAP);

    // done arrives the cycle after the last shift, so mask it out
    assign sw_pe_en = (state == S_SHIFT) && !sh.shift_done;

    assign sh.fill_kick  = (state == S_KICK_FILL);
    assign sh.shift_kick = (state == S_KICK_SHIFT);
    assign sh.accu_base  = accu_base_q;

    assign mp_accu_init = accu_init_q;
    assign mp_accu_base = accu_step_q;

endmodule
